// File: rob_cfg_pkg.sv
package rob_cfg_pkg;

  // ====================
  // buffer geometry
  // ====================

  // entry count with one instruction in each
  parameter int unsigned rob_depth = 8;

  // decode lanes allocating per cycle
  parameter int unsigned alloc_width = 2;

  // head entries that may retire per cycle
  parameter int unsigned commit_width = 2;

  // index and wrap pointer widths
  parameter int unsigned rob_idx_w = $clog2(rob_depth);
  parameter int unsigned rob_ptr_w = rob_idx_w + 1;

  typedef logic [rob_idx_w-1:0] rob_idx_t;

  // msb is the wrap bit
  typedef logic [rob_ptr_w-1:0] rob_ptr_t;

endpackage

// File: rob_types_pkg.sv
package rob_types_pkg;

  // ====================
  // buffer entry
  // ====================

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  arch_reg;
    logic        complete;
    logic        is_store;
    logic        excp;
    logic        br_redirect;
    logic [31:0] br_target;
    logic [31:0] wdata;
  } rob_entry_t;

  // ====================
  // writeback payloads
  // ====================

  // the alu port may carry a branch redirect
  typedef struct packed {
    rob_cfg_pkg::rob_idx_t rob_idx;
    logic [31:0]           wdata;
    logic                  br_redirect;
    logic [31:0]           br_target;
  } alu_wb_t;

  // the memory port may carry an exception
  typedef struct packed {
    rob_cfg_pkg::rob_idx_t rob_idx;
    logic [31:0]           wdata;
    logic                  excp;
    logic                  is_store;
  } mem_wb_t;

endpackage

// File: rob_wb_if.sv
// writeback request from one execution unit into the buffer
interface rob_wb_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t payload;

  // held by the source until valid and ready meet on a rising edge
  modport src (
    output valid,
    output payload,
    input  ready
  );

  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: rob_cmt_if.sv
// head of the buffer as seen by the commit unit
interface rob_cmt_if ();
  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  logic [commit_width-1:0]       head_valid;
  rob_entry_t [commit_width-1:0] head_entry;
  // entries retired this cycle (0 to 2)
  logic [1:0]                    commit_cnt;

  modport rob (
    output head_valid,
    output head_entry,
    input  commit_cnt
  );

  modport cmt (
    input  head_valid,
    input  head_entry,
    output commit_cnt
  );

endinterface

// File: wb_slot.sv
module wb_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,
  rob_wb_if.src    out
);

  logic     valid_q;
  payload_t payload_q;

  // free when empty, or when the held request leaves this cycle
  assign in_ready = !valid_q || out.ready;

  assign out.valid   = valid_q;
  assign out.payload = payload_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      payload_q <= in_payload;
    end
  end

endmodule

// File: reorder_buffer.sv
module reorder_buffer (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           flush,
  input  logic [rob_cfg_pkg::alloc_width-1:0]            alloc_valid,
  input  logic [rob_cfg_pkg::alloc_width-1:0][31:0]      alloc_pc,
  input  logic [rob_cfg_pkg::alloc_width-1:0][4:0]       alloc_arch_reg,
  input  logic [rob_cfg_pkg::alloc_width-1:0]            alloc_excp,
  output logic                                           alloc_ready,
  output rob_cfg_pkg::rob_idx_t [rob_cfg_pkg::alloc_width-1:0] alloc_idx,
  rob_wb_if.dst                                          alu_wb,
  rob_wb_if.dst                                          mem_wb,
  rob_cmt_if.rob                                         cmt
);
  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  rob_entry_t                    entry_q [rob_depth];
  rob_ptr_t                      head_q;
  rob_ptr_t                      tail_q;
  logic [rob_ptr_w-1:0]          count_q;
  logic                          alloc_en_q;

  logic [alloc_width-1:0]        alloc_fire;
  logic [$clog2(alloc_width):0]  alloc_cnt;
  rob_idx_t [commit_width-1:0]   head_idx;

  // ====================
  // allocation
  // ====================

  // room for a full decode group and held off for a cycle after reset
  assign alloc_ready = alloc_en_q && (count_q <= rob_depth - alloc_width) && !flush;
  assign alloc_fire  = alloc_valid & {alloc_width{alloc_ready}};

  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < alloc_width; i++) begin
      alloc_idx[i] = tail_q[rob_idx_w-1:0] + rob_idx_t'(i);
      alloc_cnt    = alloc_cnt + alloc_fire[i];
    end
  end

  // ====================
  // writeback ready
  // ====================

  assign alu_wb.ready = 1'b1;

  // stores only write back once they are the oldest entry
  assign mem_wb.ready = !mem_wb.payload.is_store || (mem_wb.payload.rob_idx == head_idx[0]);

  // ====================
  // head presentation
  // ====================

  always_comb begin
    for (int i = 0; i < commit_width; i++) begin
      head_idx[i]       = head_q[rob_idx_w-1:0] + rob_idx_t'(i);
      cmt.head_entry[i] = entry_q[head_idx[i]];
    end
    cmt.head_valid[0] = (count_q != '0) && entry_q[head_idx[0]].complete;
    // younger lanes only behind a valid older lane
    for (int i = 1; i < commit_width; i++) begin
      cmt.head_valid[i] = cmt.head_valid[i-1] && (count_q > i) &&
                          entry_q[head_idx[i]].complete;
    end
  end

  // ====================
  // entry store
  // ====================

  always_ff @(posedge clk) begin
    for (int i = 0; i < alloc_width; i++) begin
      if (alloc_fire[i]) begin
        // an entry faulting at decode is already done
        entry_q[alloc_idx[i]] <= '{
          pc:          alloc_pc[i],
          arch_reg:    alloc_arch_reg[i],
          complete:    alloc_excp[i],
          is_store:    1'b0,
          excp:        alloc_excp[i],
          br_redirect: 1'b0,
          br_target:   '0,
          wdata:       '0
        };
      end
    end

    if (alu_wb.valid && alu_wb.ready) begin
      entry_q[alu_wb.payload.rob_idx].complete    <= 1'b1;
      entry_q[alu_wb.payload.rob_idx].wdata       <= alu_wb.payload.wdata;
      entry_q[alu_wb.payload.rob_idx].br_redirect <= alu_wb.payload.br_redirect;
      entry_q[alu_wb.payload.rob_idx].br_target   <= alu_wb.payload.br_target;
    end

    if (mem_wb.valid && mem_wb.ready) begin
      entry_q[mem_wb.payload.rob_idx].complete <= 1'b1;
      entry_q[mem_wb.payload.rob_idx].wdata    <= mem_wb.payload.wdata;
      entry_q[mem_wb.payload.rob_idx].excp     <= mem_wb.payload.excp;
      entry_q[mem_wb.payload.rob_idx].is_store <= mem_wb.payload.is_store;
    end
  end

  // pointer control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      alloc_en_q <= 1'b0;
    end else begin
      alloc_en_q <= 1'b1;
      if (flush) begin
        head_q  <= '0;
        tail_q  <= '0;
        count_q <= '0;
      end else begin
        head_q  <= head_q + cmt.commit_cnt;
        tail_q  <= tail_q + alloc_cnt;
        count_q <= count_q + alloc_cnt - cmt.commit_cnt;
      end
    end
  end

endmodule

// File: commit_unit.sv
module commit_unit #(
  parameter logic [31:0] exc_vector = 32'h0000_1c00
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  rob_cmt_if.cmt                                     cmt,
  output logic [rob_cfg_pkg::commit_width-1:0]       retire_valid,
  output logic [rob_cfg_pkg::commit_width-1:0][31:0] retire_pc,
  output logic [rob_cfg_pkg::commit_width-1:0][4:0]  retire_arch_reg,
  output logic [rob_cfg_pkg::commit_width-1:0][31:0] retire_wdata,
  output logic [31:0]                                retire_count,
  output logic                                       flush,
  output logic                                       redirect_pc_valid_unused_n,
  output logic [31:0]                                redirect_pc
);
  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  rob_entry_t              lane0_entry;
  rob_entry_t              lane1_entry;
  logic                    lane0_flush;
  logic [commit_width-1:0] retire_sel;

  assign lane0_entry = cmt.head_entry[0];
  assign lane1_entry = cmt.head_entry[1];
  assign lane0_flush = lane0_entry.br_redirect || lane0_entry.excp;

  // ====================
  // retire selection
  // ====================

  // nothing retires while the flush is in flight
  assign retire_sel[0] = cmt.head_valid[0] && !flush;

  // redirects and exceptions always retire alone in lane 0
  assign retire_sel[1] = retire_sel[0] && cmt.head_valid[1] && !lane0_flush &&
                         !lane0_entry.is_store && !lane1_entry.br_redirect &&
                         !lane1_entry.excp;

  assign cmt.commit_cnt = {1'b0, retire_sel[0]} + {1'b0, retire_sel[1]};

  assign redirect_pc_valid_unused_n = !flush;

  // ====================
  // retire registers
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= '0;
      retire_count <= '0;
      flush        <= 1'b0;
    end else begin
      retire_valid <= retire_sel;
      retire_count <= retire_count + 32'(cmt.commit_cnt);
      flush        <= retire_sel[0] && lane0_flush;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < commit_width; i++) begin
      retire_pc[i]       <= cmt.head_entry[i].pc;
      retire_arch_reg[i] <= cmt.head_entry[i].arch_reg;
      retire_wdata[i]    <= cmt.head_entry[i].wdata;
    end
    // exception wins over a redirect on the same entry
    redirect_pc <= lane0_entry.excp ? exc_vector : lane0_entry.br_target;
  end

endmodule

// File: rob_top.sv
module rob_top #(
  parameter logic [31:0] exc_vector = 32'h0000_1c00
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [rob_cfg_pkg::alloc_width-1:0]              alloc_valid,
  input  logic [rob_cfg_pkg::alloc_width-1:0][31:0]        alloc_pc,
  input  logic [rob_cfg_pkg::alloc_width-1:0][4:0]         alloc_arch_reg,
  input  logic [rob_cfg_pkg::alloc_width-1:0]              alloc_excp,
  output logic                                             alloc_ready,
  output rob_cfg_pkg::rob_idx_t [rob_cfg_pkg::alloc_width-1:0] alloc_idx,
  input  logic                                             alu_valid,
  output logic                                             alu_ready,
  input  rob_cfg_pkg::rob_idx_t                            alu_rob_idx,
  input  logic [31:0]                                      alu_wdata,
  input  logic                                             alu_br_redirect,
  input  logic [31:0]                                      alu_br_target,
  input  logic                                             mem_valid,
  output logic                                             mem_ready,
  input  rob_cfg_pkg::rob_idx_t                            mem_rob_idx,
  input  logic [31:0]                                      mem_wdata,
  input  logic                                             mem_excp,
  input  logic                                             mem_is_store,
  output logic [rob_cfg_pkg::commit_width-1:0]             retire_valid,
  output logic [rob_cfg_pkg::commit_width-1:0][31:0]       retire_pc,
  output logic [rob_cfg_pkg::commit_width-1:0][4:0]        retire_arch_reg,
  output logic [rob_cfg_pkg::commit_width-1:0][31:0]       retire_wdata,
  output logic [31:0]                                      retire_count,
  output logic                                             flush,
  output logic [31:0]                                      redirect_pc
);
  import rob_types_pkg::*;

  alu_wb_t alu_payload;
  mem_wb_t mem_payload;

  rob_wb_if #(.payload_t(alu_wb_t)) alu_wb_if ();
  rob_wb_if #(.payload_t(mem_wb_t)) mem_wb_if ();
  rob_cmt_if                        cmt_if ();

  // pack the plain writeback ports
  assign alu_payload = '{rob_idx: alu_rob_idx, wdata: alu_wdata,
                         br_redirect: alu_br_redirect, br_target: alu_br_target};
  assign mem_payload = '{rob_idx: mem_rob_idx, wdata: mem_wdata,
                         excp: mem_excp, is_store: mem_is_store};

  wb_slot #(.payload_t(alu_wb_t)) u_alu_slot (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_valid(alu_valid), .in_ready(alu_ready), .in_payload(alu_payload),
    .out(alu_wb_if)
  );

  wb_slot #(.payload_t(mem_wb_t)) u_mem_slot (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .in_valid(mem_valid), .in_ready(mem_ready), .in_payload(mem_payload),
    .out(mem_wb_if)
  );

  reorder_buffer u_rob (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .alloc_valid(alloc_valid), .alloc_pc(alloc_pc), .alloc_arch_reg(alloc_arch_reg),
    .alloc_excp(alloc_excp), .alloc_ready(alloc_ready), .alloc_idx(alloc_idx),
    .alu_wb(alu_wb_if), .mem_wb(mem_wb_if), .cmt(cmt_if)
  );

  commit_unit #(.exc_vector(exc_vector)) u_commit (
    .clk(clk), .rst_n(rst_n), .cmt(cmt_if),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_arch_reg(retire_arch_reg), .retire_wdata(retire_wdata),
    .retire_count(retire_count), .flush(flush),
    .redirect_pc_valid_unused_n(), .redirect_pc(redirect_pc)
  );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: rob_top_chk.sv
module rob_top_chk #(
  parameter logic [31:0] exc_vector = 32'h0000_1c00
) (
  input logic                                       clk,
  input logic                                       rst_n,
  input logic [rob_cfg_pkg::alloc_width-1:0]        alloc_valid,
  input logic                                       alloc_ready,
  input logic                                       alu_valid,
  input logic                                       alu_ready,
  input logic                                       alu_br_redirect,
  input logic [31:0]                                alu_br_target,
  input logic [rob_cfg_pkg::commit_width-1:0]       retire_valid,
  input logic [rob_cfg_pkg::commit_width-1:0][31:0] retire_pc,
  input logic [rob_cfg_pkg::commit_width-1:0][4:0]  retire_arch_reg,
  input logic [rob_cfg_pkg::commit_width-1:0][31:0] retire_wdata,
  input logic [31:0]                                retire_count,
  input logic                                       flush,
  input logic [31:0]                                redirect_pc
);
  import rob_cfg_pkg::*;

  int          fail_cnt = 0;
  int          occ;
  int          ret_n;
  logic        started;
  logic        have_pc;
  logic        flush_q;
  logic [31:0] exp_pc;
  logic [31:0] tgt_q;
  logic [31:0] count_q;

  assign ret_n = $countones(retire_valid);

  // ====================
  // reference model
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ     <= 0;
      started <= 1'b0;
      have_pc <= 1'b0;
      flush_q <= 1'b0;
      exp_pc  <= '0;
      tgt_q   <= '0;
      count_q <= '0;
    end else begin
      started <= 1'b1;
      flush_q <= flush;
      count_q <= retire_count;
      if (alu_valid && alu_ready && alu_br_redirect) begin
        tgt_q <= alu_br_target;
      end
      if (flush) begin
        // younger entries are gone and fetch restarts at the redirect
        occ     <= 0;
        exp_pc  <= redirect_pc;
        have_pc <= 1'b1;
      end else begin
        occ <= occ + $countones(alloc_valid & {alloc_width{alloc_ready}}) - ret_n;
        if (retire_valid != '0) begin
          exp_pc  <= retire_pc[ret_n-1] + 32'd4;
          have_pc <= 1'b1;
        end
      end
    end
  end

  // ====================
  // assertions
  // ====================

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_valid[0] && have_pc) |-> retire_pc[0] == exp_pc)
    else begin
      $error("retired pc breaks program order");
      fail_cnt++;
    end

  a_pair: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid[1] |-> retire_valid[0] && retire_pc[1] == retire_pc[0] + 32'd4)
    else begin
      $error("second retire lane out of order");
      fail_cnt++;
    end

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    (!retire_valid[0] || retire_wdata[0] == (retire_pc[0] ^ 32'h5a5a_0000)) &&
    (!retire_valid[1] || retire_wdata[1] == (retire_pc[1] ^ 32'h5a5a_0000)))
    else begin
      $error("retired data does not match its pc");
      fail_cnt++;
    end

  // the testbench takes the destination register from pc bits 6 to 2
  a_reg: assert property (@(posedge clk) disable iff (!rst_n)
    (!retire_valid[0] || retire_arch_reg[0] == retire_pc[0][6:2]) &&
    (!retire_valid[1] || retire_arch_reg[1] == retire_pc[1][6:2]))
    else begin
      $error("retired register does not match its pc");
      fail_cnt++;
    end

  // buffer count is the model minus the lanes shown this cycle
  a_occ: assert property (@(posedge clk) disable iff (!rst_n)
    started |-> alloc_ready == ((occ - ret_n <= int'(rob_depth - alloc_width)) && !flush))
    else begin
      $error("alloc_ready disagrees with occupancy");
      fail_cnt++;
    end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> retire_valid == 2'b01 && (redirect_pc == tgt_q || redirect_pc == exc_vector))
    else begin
      $error("flush without a lone retire or with a bad target");
      fail_cnt++;
    end

  a_flush_end: assert property (@(posedge clk) disable iff (!rst_n)
    flush_q |-> !flush && retire_valid == '0)
    else begin
      $error("flush longer than one cycle or retire right after it");
      fail_cnt++;
    end

  a_count: assert property (@(posedge clk) disable iff (!rst_n)
    started |-> retire_count == count_q + ret_n)
    else begin
      $error("retire_count step differs from retire lanes");
      fail_cnt++;
    end

endmodule

bind rob_top rob_top_chk #(.exc_vector(exc_vector)) u_chk (.*);

// File: tb_rob_top.sv
module tb_rob_top;
  import rob_cfg_pkg::*;

  localparam logic [31:0] exc_vector = 32'h0000_1c00;
  localparam logic [31:0] br_target  = 32'h0000_4000;
  localparam logic [31:0] wdata_mask = 32'h5a5a_0000;
  localparam int          n_instr    = 200;
  // worst case of about 20 cycles per instruction
  localparam int          max_cycles = n_instr * 20;

  logic                          clk, rst_n;
  logic [alloc_width-1:0]        alloc_valid, alloc_excp;
  logic [alloc_width-1:0][31:0]  alloc_pc;
  logic [alloc_width-1:0][4:0]   alloc_arch_reg;
  logic                          alloc_ready;
  rob_idx_t [alloc_width-1:0]    alloc_idx;
  logic                          alu_valid, alu_ready, alu_br_redirect;
  logic                          mem_valid, mem_ready, mem_excp, mem_is_store;
  rob_idx_t                      alu_rob_idx, mem_rob_idx;
  logic [31:0]                   alu_wdata, alu_br_target, mem_wdata;
  logic [commit_width-1:0]       retire_valid;
  logic [commit_width-1:0][31:0] retire_pc, retire_wdata;
  logic [commit_width-1:0][4:0]  retire_arch_reg;
  logic [31:0]                   retire_count, redirect_pc;
  logic                          flush;

  int          seed = 32'h39d7;
  int          n_alloc, n_squash, errors, cycles;
  logic [31:0] next_pc, special_pc;
  bit          special_branch;
  // pending writebacks with kinds 0 alu, 1 load, 2 store, 3 branch and 4 faulting load
  rob_idx_t    q_idx[$];
  logic [31:0] q_pc[$];
  int          q_kind[$];

  tb_clk_gen #(.period(4), .reset_cycles(5)) u_clk (.clk(clk), .rst_n(rst_n));

  rob_top #(.exc_vector(exc_vector)) uut (.*);

  function automatic bit is_mem(input int kind);
    return kind == 1 || kind == 2 || kind == 4;
  endfunction

  // ====================
  // stimulus tasks
  // ====================

  task automatic alloc_burst();
    int unsigned r;
    int          lanes;
    int          v;
    r = $random(seed);
    lanes = r % 3;
    for (int i = 0; i < lanes; i++) begin
      if (alloc_ready && n_alloc < n_instr) begin
        alloc_valid[i]    = 1'b1;
        alloc_pc[i]       = next_pc;
        // destination register follows the pc
        alloc_arch_reg[i] = next_pc[6:2];
        v = r[20 + 2 * i +: 2];
        if (n_alloc == 60 || n_alloc == 130) begin
          special_pc     = next_pc;
          special_branch = (n_alloc == 60);
          v = special_branch ? 3 : 4;
        end else begin
          v = (v < 2) ? 0 : v - 1;
        end
        q_idx.push_back(alloc_idx[i]);
        q_pc.push_back(next_pc);
        q_kind.push_back(v);
        n_alloc++;
        next_pc += 32'd4;
      end
    end
  endtask

  task automatic send_writeback(input bit mem_side);
    int unsigned r;
    int          n;
    int          sel;
    int          k;
    r = $random(seed);
    n = q_kind.size();
    sel = -1;
    for (int j = 0; j < n; j++) begin
      k = (r + j) % n;
      if (sel < 0 && is_mem(q_kind[k]) == mem_side) sel = k;
    end
    // a store goes out only as the oldest memory op
    if (sel >= 0 && q_kind[sel] == 2) begin
      for (int j = n - 1; j >= 0; j--) begin
        if (is_mem(q_kind[j])) sel = j;
      end
    end
    if (sel >= 0 && r[31:30] != 2'b00) begin
      if (mem_side) begin
        mem_valid    = 1'b1;
        mem_rob_idx  = q_idx[sel];
        mem_wdata    = q_pc[sel] ^ wdata_mask;
        mem_excp     = (q_kind[sel] == 4);
        mem_is_store = (q_kind[sel] == 2);
      end else begin
        alu_valid       = 1'b1;
        alu_rob_idx     = q_idx[sel];
        alu_wdata       = q_pc[sel] ^ wdata_mask;
        alu_br_redirect = (q_kind[sel] == 3);
        alu_br_target   = (q_kind[sel] == 3) ? br_target : '0;
      end
      q_idx.delete(sel);
      q_pc.delete(sel);
      q_kind.delete(sel);
    end
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    alloc_valid     = '0;
    alloc_excp      = '0;
    alloc_pc        = '0;
    alloc_arch_reg  = '0;
    alu_valid       = 1'b0;
    alu_rob_idx     = '0;
    alu_wdata       = '0;
    alu_br_redirect = 1'b0;
    alu_br_target   = '0;
    mem_valid       = 1'b0;
    mem_rob_idx     = '0;
    mem_wdata       = '0;
    mem_excp        = 1'b0;
    mem_is_store    = 1'b0;
    n_alloc         = 0;
    n_squash        = 0;
    errors          = 0;
    next_pc         = 32'h0000_0100;
    special_pc      = '0;
    special_branch  = 1'b0;
    wait (rst_n === 1'b1);
    while (n_alloc < n_instr || q_kind.size() != 0 ||
           retire_count < n_alloc - n_squash) begin
      @(negedge clk);
      alloc_valid = '0;
      alu_valid   = 1'b0;
      mem_valid   = 1'b0;
      if (flush) begin
        // everything younger than the flushing entry is squashed
        n_squash += (next_pc - special_pc) / 4 - 1;
        next_pc = special_branch ? br_target : exc_vector;
        q_idx.delete();
        q_pc.delete();
        q_kind.delete();
      end else begin
        if (alu_ready) send_writeback(1'b0);
        if (mem_ready) send_writeback(1'b1);
        alloc_burst();
      end
    end
    if (retire_count != n_alloc - n_squash) begin
      $display("Fail at time %0t: retire_count %0d, expected %0d",
               $time, retire_count, n_alloc - n_squash);
      errors++;
    end
    $display("checker failures %0d, testbench errors %0d", uut.u_chk.fail_cnt, errors);
    if (uut.u_chk.fail_cnt == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial cycles = 0;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run timed out after %0d cycles without retiring all instructions", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

// File: rob_top.f
rob_cfg_pkg.sv
rob_types_pkg.sv
rob_wb_if.sv
rob_cmt_if.sv
wb_slot.sv
reorder_buffer.sv
commit_unit.sv
rob_top.sv
tb_clk_gen.sv
rob_top_chk.sv
tb_rob_top.sv

// File: Bender.yml
package:
  name: rob_top

sources:
  - rob_cfg_pkg.sv
  - rob_types_pkg.sv
  - rob_wb_if.sv
  - rob_cmt_if.sv
  - wb_slot.sv
  - reorder_buffer.sv
  - commit_unit.sv
  - rob_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rob_top_chk.sv
      - tb_rob_top.sv
